/* src/rv_isa_pkg.sv */
// RV32I instruction set definitions
`default_nettype none

package rv_isa_pkg;

    typedef logic [31:0] word;
    typedef logic [4:0]  reg_idx_t;

    // addi x0, x0, 0
    parameter word NOP_INSTR = 32'h0000_0013;

    // base opcode map
    typedef enum logic [6:0] {
        OP_LUI    = 7'b0110111,
        OP_AUIPC  = 7'b0010111,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_BRANCH = 7'b1100011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_ALUI   = 7'b0010011,
        OP_ALU    = 7'b0110011,
        OP_FENCE  = 7'b0001111,
        OP_SYSTEM = 7'b1110011
    } opcode_t;

    typedef struct packed {
        logic [6:0] funct7;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        reg_idx_t   rd;
        opcode_t    opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm12;
        reg_idx_t    rs1;
        logic [2:0]  funct3;
        reg_idx_t    rd;
        opcode_t     opcode;
    } i_fmt_t;

    // same word, two field layouts
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
    } instr_u;

    // funct3 of OP and OP-IMM
    typedef enum logic [2:0] {
        ALU_ADD  = 3'b000,
        ALU_SLL  = 3'b001,
        ALU_SLT  = 3'b010,
        ALU_SLTU = 3'b011,
        ALU_XOR  = 3'b100,
        ALU_SR   = 3'b101,
        ALU_OR   = 3'b110,
        ALU_AND  = 3'b111
    } alu_op_t;

    // funct3 of BRANCH
    typedef enum logic [2:0] {
        BL_BEQ  = 3'b000,
        BL_BNE  = 3'b001,
        BL_BLT  = 3'b100,
        BL_BGE  = 3'b101,
        BL_BLTU = 3'b110,
        BL_BGEU = 3'b111
    } branch_op_t;

    // low two bits of load/store funct3
    typedef enum logic [1:0] {
        MEM_BYTE = 2'b00,
        MEM_HALF = 2'b01,
        MEM_WORD = 2'b10
    } mem_width_t;

endpackage

`default_nettype wire

/* src/rv_core_pkg.sv */
// core control and memory port types
`default_nettype none

package rv_core_pkg;

    // alu operand sources
    typedef enum logic [1:0] {
        A_ZERO = 2'b00,
        A_RS1  = 2'b01,
        A_PC   = 2'b10
    } alu_a_sel_t;

    typedef enum logic [1:0] {
        B_IMM = 2'b00,
        B_RS2 = 2'b01
    } alu_b_sel_t;

    // register write-back source
    typedef enum logic [1:0] {
        WB_ALU       = 2'b00,
        WB_MEM       = 2'b01,
        WB_PC_PLUS_4 = 2'b10
    } wb_sel_t;

    typedef struct packed {
        alu_a_sel_t             alu_a_sel;
        alu_b_sel_t             alu_b_sel;
        rv_isa_pkg::alu_op_t    alu_op;
        logic                   sub_arith;
        logic                   branch_instr;
        logic                   branch_always;
        rv_isa_pkg::branch_op_t branch_op;
        logic                   jump_reg;
        logic                   mem_read;
        logic                   mem_write;
        rv_isa_pkg::mem_width_t mem_width;
        logic                   mem_unsigned;
        wb_sel_t                wb_sel;
        logic                   wb_enable;
    } ctrl_t;

    typedef struct packed {
        rv_isa_pkg::word addr;
    } imem_req_t;

    typedef struct packed {
        rv_isa_pkg::word addr;
        rv_isa_pkg::word wdata;
        logic [3:0]      be;
        logic            read;
        logic            write;
    } dmem_req_t;

endpackage

`default_nettype wire

/* src/rv_decoder.sv */
// RV32I instruction decoder
`default_nettype none

module rv_decoder (
    input  rv_isa_pkg::word      instr,
    output rv_core_pkg::ctrl_t   ctrl,
    output rv_isa_pkg::word      imm,
    output rv_isa_pkg::reg_idx_t rs1_idx,
    output rv_isa_pkg::reg_idx_t rs2_idx,
    output rv_isa_pkg::reg_idx_t rd_idx
);
    import rv_isa_pkg::*;
    import rv_core_pkg::*;

    instr_u iu;
    word    imm_i;
    word    imm_s;
    word    imm_b;
    word    imm_u;
    word    imm_j;

    assign iu = instr;

    // register fields sit at the same place in every format
    assign rs1_idx = iu.r_fmt.rs1;
    assign rs2_idx = iu.r_fmt.rs2;
    assign rd_idx  = iu.r_fmt.rd;

    // immediates, all sign extended from bit 31
    assign imm_i = {{20{iu.i_fmt.imm12[11]}}, iu.i_fmt.imm12};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        // quiet defaults, nothing written and no memory access
        ctrl               = '0;
        ctrl.alu_a_sel     = A_ZERO;
        ctrl.alu_b_sel     = B_IMM;
        ctrl.alu_op        = ALU_ADD;
        ctrl.branch_op     = BL_BEQ;
        ctrl.mem_width     = MEM_WORD;
        ctrl.wb_sel        = WB_ALU;
        imm                = '0;

        case (iu.r_fmt.opcode)
            OP_LUI: begin
                imm            = imm_u;
                ctrl.wb_enable = 1'b1;
            end

            OP_AUIPC: begin
                imm            = imm_u;
                ctrl.alu_a_sel = A_PC;
                ctrl.wb_enable = 1'b1;
            end

            OP_JAL: begin
                imm                = imm_j;
                ctrl.alu_a_sel     = A_PC;
                ctrl.branch_always = 1'b1;
                ctrl.wb_sel        = WB_PC_PLUS_4;
                ctrl.wb_enable     = 1'b1;
            end

            OP_JALR: begin
                // target comes out of the alu as rs1 + imm
                imm                = imm_i;
                ctrl.alu_a_sel     = A_RS1;
                ctrl.branch_always = 1'b1;
                ctrl.jump_reg      = 1'b1;
                ctrl.wb_sel        = WB_PC_PLUS_4;
                ctrl.wb_enable     = 1'b1;
            end

            OP_BRANCH: begin
                imm               = imm_b;
                ctrl.alu_a_sel    = A_PC;
                ctrl.branch_instr = 1'b1;
                ctrl.branch_op    = branch_op_t'(iu.r_fmt.funct3);
            end

            OP_LOAD: begin
                imm               = imm_i;
                ctrl.alu_a_sel    = A_RS1;
                ctrl.mem_read     = 1'b1;
                ctrl.mem_width    = mem_width_t'(iu.r_fmt.funct3[1:0]);
                ctrl.mem_unsigned = iu.r_fmt.funct3[2];
                ctrl.wb_sel       = WB_MEM;
                ctrl.wb_enable    = 1'b1;
            end

            OP_STORE: begin
                imm            = imm_s;
                ctrl.alu_a_sel = A_RS1;
                ctrl.mem_write = 1'b1;
                ctrl.mem_width = mem_width_t'(iu.r_fmt.funct3[1:0]);
            end

            OP_ALUI: begin
                imm            = imm_i;
                ctrl.alu_a_sel = A_RS1;
                ctrl.alu_op    = alu_op_t'(iu.r_fmt.funct3);
                // bit 30 is part of the immediate unless this is a shift
                ctrl.sub_arith = (iu.r_fmt.funct3 == ALU_SR) && instr[30];
                ctrl.wb_enable = 1'b1;
            end

            OP_ALU: begin
                ctrl.alu_a_sel = A_RS1;
                ctrl.alu_b_sel = B_RS2;
                ctrl.alu_op    = alu_op_t'(iu.r_fmt.funct3);
                ctrl.sub_arith = instr[30];
                ctrl.wb_enable = 1'b1;
            end

            // no csr and no memory ordering, both retire as no-ops
            OP_FENCE, OP_SYSTEM: begin
                ctrl.wb_enable = 1'b0;
            end

            default: begin
                ctrl.wb_enable = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* src/rv_regfile.sv */
// integer register file
`default_nettype none

module rv_regfile (
    input  logic                 clk,
    input  logic                 rst,
    input  rv_isa_pkg::reg_idx_t rs1_idx,
    input  rv_isa_pkg::reg_idx_t rs2_idx,
    input  rv_isa_pkg::reg_idx_t rd_idx,
    input  rv_core_pkg::ctrl_t   ctrl,
    input  rv_isa_pkg::word      alu_result,
    input  rv_isa_pkg::word      load_data,
    input  rv_isa_pkg::word      pc,
    output rv_isa_pkg::word      rs1_data,
    output rv_isa_pkg::word      rs2_data
);
    import rv_isa_pkg::*;
    import rv_core_pkg::*;

    word regs [32];
    word wb_data;

    // write-back source
    always_comb begin
        case (ctrl.wb_sel)
            WB_MEM:       wb_data = load_data;
            WB_PC_PLUS_4: wb_data = pc + 32'd4;
            default:      wb_data = alu_result;
        endcase
    end

    // x0 reads as zero
    assign rs1_data = (rs1_idx == '0) ? '0 : regs[rs1_idx];
    assign rs2_data = (rs2_idx == '0) ? '0 : regs[rs2_idx];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (ctrl.wb_enable && (rd_idx != '0)) begin
            regs[rd_idx] <= wb_data;
        end
    end

endmodule

`default_nettype wire

/* src/rv_alu.sv */
// integer ALU
`default_nettype none

module rv_alu (
    input  rv_core_pkg::ctrl_t ctrl,
    input  rv_isa_pkg::word    rs1_data,
    input  rv_isa_pkg::word    rs2_data,
    input  rv_isa_pkg::word    imm,
    input  rv_isa_pkg::word    pc,
    output rv_isa_pkg::word    result
);
    import rv_isa_pkg::*;
    import rv_core_pkg::*;

    word        a;
    word        b;
    logic [4:0] shamt;

    // operand selection
    always_comb begin
        case (ctrl.alu_a_sel)
            A_RS1:   a = rs1_data;
            A_PC:    a = pc;
            default: a = '0;
        endcase
        b = (ctrl.alu_b_sel == B_RS2) ? rs2_data : imm;
    end

    assign shamt = b[4:0];

    always_comb begin
        case (ctrl.alu_op)
            ALU_ADD:  result = ctrl.sub_arith ? (a - b) : (a + b);
            ALU_SLL:  result = a << shamt;
            ALU_SLT:  result = {31'b0, $signed(a) < $signed(b)};
            ALU_SLTU: result = {31'b0, a < b};
            ALU_XOR:  result = a ^ b;
            // sra when bit 30 set, srl otherwise
            ALU_SR:   result = ctrl.sub_arith ? word'($signed(a) >>> shamt) : (a >> shamt);
            ALU_OR:   result = a | b;
            ALU_AND:  result = a & b;
            default:  result = '0;
        endcase
    end

endmodule

`default_nettype wire

/* src/rv_pc_unit.sv */
// program counter and branch unit
`default_nettype none

module rv_pc_unit #(
    parameter rv_isa_pkg::word RESET_PC = 32'h0000_0000
) (
    input  logic               clk,
    input  logic               rst,
    input  rv_core_pkg::ctrl_t ctrl,
    input  rv_isa_pkg::word    rs1_data,
    input  rv_isa_pkg::word    rs2_data,
    input  rv_isa_pkg::word    imm,
    input  rv_isa_pkg::word    alu_result,
    output rv_isa_pkg::word    pc
);
    import rv_isa_pkg::*;
    import rv_core_pkg::*;

    logic taken;
    word  pc_next;

    // branch condition
    always_comb begin
        case (ctrl.branch_op)
            BL_BEQ:  taken = (rs1_data == rs2_data);
            BL_BNE:  taken = (rs1_data != rs2_data);
            BL_BLT:  taken = ($signed(rs1_data) < $signed(rs2_data));
            BL_BGE:  taken = ($signed(rs1_data) >= $signed(rs2_data));
            BL_BLTU: taken = (rs1_data < rs2_data);
            BL_BGEU: taken = (rs1_data >= rs2_data);
            default: taken = 1'b0;
        endcase
    end

    always_comb begin
        if (ctrl.branch_always && ctrl.jump_reg) begin
            // jalr clears the low bit of the target
            pc_next = {alu_result[31:1], 1'b0};
        end else if (ctrl.branch_always || (ctrl.branch_instr && taken)) begin
            pc_next = pc + imm;
        end else begin
            pc_next = pc + 32'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= RESET_PC;
        end else begin
            pc <= pc_next;
        end
    end

endmodule

`default_nettype wire

/* src/rv_lsu.sv */
// load/store alignment unit
`default_nettype none

module rv_lsu (
    input  rv_core_pkg::ctrl_t     ctrl,
    input  rv_isa_pkg::word        alu_result,
    input  rv_isa_pkg::word        rs2_data,
    input  rv_isa_pkg::word        dmem_rdata,
    output rv_core_pkg::dmem_req_t dmem,
    output rv_isa_pkg::word        load_data
);
    import rv_isa_pkg::*;
    import rv_core_pkg::*;

    logic [1:0] offset;
    word        raw;

    assign offset = alu_result[1:0];

    // store side, data repeated on every lane and be picks the lane
    always_comb begin
        dmem.addr  = alu_result;
        dmem.read  = ctrl.mem_read;
        dmem.write = ctrl.mem_write;
        case (ctrl.mem_width)
            MEM_BYTE: begin
                dmem.wdata = {4{rs2_data[7:0]}};
                dmem.be    = 4'b0001 << offset;
            end
            MEM_HALF: begin
                dmem.wdata = {2{rs2_data[15:0]}};
                dmem.be    = 4'b0011 << {offset[1], 1'b0};
            end
            default: begin
                dmem.wdata = rs2_data;
                dmem.be    = 4'b1111;
            end
        endcase
    end

    // addressed lane moved down to bit 0
    assign raw = dmem_rdata >> {offset, 3'b000};

    always_comb begin
        case (ctrl.mem_width)
            MEM_BYTE: begin
                load_data = ctrl.mem_unsigned ? {24'b0, raw[7:0]} : {{24{raw[7]}}, raw[7:0]};
            end
            MEM_HALF: begin
                load_data = ctrl.mem_unsigned ? {16'b0, raw[15:0]}
                                              : {{16{raw[15]}}, raw[15:0]};
            end
            default: load_data = dmem_rdata;
        endcase
    end

endmodule

`default_nettype wire

/* src/rv_core.sv */
// single-cycle RV32I core
`default_nettype none

module rv_core #(
    parameter rv_isa_pkg::word RESET_PC = 32'h0000_0000
) (
    input  logic                   clk,
    input  logic                   rst,
    output rv_core_pkg::imem_req_t imem,
    input  rv_isa_pkg::word        imem_rdata,
    output rv_core_pkg::dmem_req_t dmem,
    input  rv_isa_pkg::word        dmem_rdata
);
    import rv_isa_pkg::*;
    import rv_core_pkg::*;

    word      pc;
    word      instr;
    word      imm;
    word      rs1_data;
    word      rs2_data;
    word      result;
    word      load_data;
    reg_idx_t rs1_idx;
    reg_idx_t rs2_idx;
    reg_idx_t rd_idx;
    ctrl_t    ctrl;

    assign imem.addr = pc;

    // decoder sees a nop in reset so strobes and writes stay quiet
    assign instr = rst ? NOP_INSTR : imem_rdata;

    rv_pc_unit #(
        .RESET_PC (RESET_PC)
    ) pc_unit0 (
        .clk        (clk),
        .rst        (rst),
        .ctrl       (ctrl),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .imm        (imm),
        .alu_result (result),
        .pc         (pc)
    );

    rv_decoder decoder0 (
        .instr   (instr),
        .ctrl    (ctrl),
        .imm     (imm),
        .rs1_idx (rs1_idx),
        .rs2_idx (rs2_idx),
        .rd_idx  (rd_idx)
    );

    rv_regfile regfile0 (
        .clk        (clk),
        .rst        (rst),
        .rs1_idx    (rs1_idx),
        .rs2_idx    (rs2_idx),
        .rd_idx     (rd_idx),
        .ctrl       (ctrl),
        .alu_result (result),
        .load_data  (load_data),
        .pc         (pc),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data)
    );

    rv_alu alu0 (
        .ctrl     (ctrl),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .imm      (imm),
        .pc       (pc),
        .result   (result)
    );

    rv_lsu lsu0 (
        .ctrl       (ctrl),
        .alu_result (result),
        .rs2_data   (rs2_data),
        .dmem_rdata (dmem_rdata),
        .dmem       (dmem),
        .load_data  (load_data)
    );

endmodule

`default_nettype wire

/* verif/rv_core_sva.sv */
// data port assertions
`default_nettype none

module rv_core_sva (
    input logic                   clk,
    input logic                   rst,
    input rv_core_pkg::dmem_req_t dmem
);

    // decoder is fed a nop while reset is high
    quiet_in_reset: assert property (@(posedge clk) rst |-> !(dmem.read || dmem.write))
        else $error("dmem strobe asserted during reset");

    one_strobe: assert property (@(posedge clk) !(dmem.read && dmem.write))
        else $error("dmem read and write asserted together");

    // a write has to enable at least one lane
    write_has_lanes: assert property (@(posedge clk) disable iff (rst)
        dmem.write |-> (dmem.be != 4'b0000))
        else $error("dmem write with no byte enable");

endmodule

bind rv_core rv_core_sva sva0 (
    .clk  (clk),
    .rst  (rst),
    .dmem (dmem)
);

`default_nettype wire

/* verif/rv_core_checker.sv */
// store checker for the core
`default_nettype none

module rv_core_checker #(
    parameter rv_isa_pkg::word RESET_PC   = 32'h0000_0000,
    parameter int              MAX_STORES = 64
) (
    input  logic                   clk,
    input  logic                   rst,
    input  rv_core_pkg::imem_req_t imem,
    input  rv_core_pkg::dmem_req_t dmem,
    input  rv_core_pkg::dmem_req_t exp_stores [MAX_STORES],
    input  int                     n_stores,
    output int                     store_count,
    output int                     value_errors,
    output int                     other_errors
);
    import rv_isa_pkg::*;
    import rv_core_pkg::*;

    int   n_seen = 0;
    int   n_value = 0;
    int   n_other = 0;
    logic first_fetch = 1'b1;

    assign store_count  = n_seen;
    assign value_errors = n_value;
    assign other_errors = n_other;

    task automatic compare_field(string what, word expected, word actual);
        if (expected !== actual) begin
            $display("ERROR %s expected %h actual %h", what, expected, actual);
            n_value++;
        end
    endtask

    always @(posedge clk) begin
        if (rst) begin
            first_fetch = 1'b1;
            if (dmem.write) begin
                $display("a store was issued while reset was high");
                n_other++;
            end
        end else begin
            // first fetch after reset comes from the boot address
            if (first_fetch) begin
                compare_field("imem.addr", RESET_PC, imem.addr);
                first_fetch = 1'b0;
            end
            if (dmem.write) begin
                if (n_seen >= n_stores) begin
                    $display("unexpected store to address %h after the last expected store",
                             dmem.addr);
                    n_other++;
                end else begin
                    compare_field($sformatf("dmem.addr (store %0d)", n_seen),
                                  exp_stores[n_seen].addr, dmem.addr);
                    compare_field($sformatf("dmem.wdata (store %0d)", n_seen),
                                  exp_stores[n_seen].wdata, dmem.wdata);
                    compare_field($sformatf("dmem.be (store %0d)", n_seen),
                                  {28'b0, exp_stores[n_seen].be}, {28'b0, dmem.be});
                end
                n_seen++;
            end
        end
    end

endmodule

`default_nettype wire

/* verif/rv_core_tb.sv */
// single-cycle core testbench
`default_nettype none

module rv_core_tb;
    import rv_isa_pkg::*;
    import rv_core_pkg::*;

    localparam word BOOT_PC    = 32'h0000_0040;
    localparam int  MAX_PROG   = 128;
    localparam int  MAX_STORES = 64;
    localparam int  TIMEOUT    = 1000;

    // x1 is negative and x2 is a small positive shift amount
    localparam word X1        = 32'hF000_0705;
    localparam word X2        = 32'h0000_0007;
    localparam word MARKER    = 32'h0000_07AD;
    localparam word LOAD_WORD = 32'h7A81_F273;

    logic      clk;
    logic      rst;
    imem_req_t imem;
    word       imem_rdata;
    dmem_req_t dmem;
    word       dmem_rdata;

    word        imem_array [256];
    logic [7:0] dmem_bytes [2048];
    word        program_words [MAX_PROG];
    dmem_req_t  exp_stores [MAX_STORES];
    int         n_prog;
    int         n_stores;
    int         slot;
    int         store_count;
    int         value_errors;
    int         other_errors;
    int         waited;
    logic       timed_out;

    rv_core #(
        .RESET_PC (BOOT_PC)
    ) dut0 (
        .clk        (clk),
        .rst        (rst),
        .imem       (imem),
        .imem_rdata (imem_rdata),
        .dmem       (dmem),
        .dmem_rdata (dmem_rdata)
    );

    rv_core_checker #(
        .RESET_PC   (BOOT_PC),
        .MAX_STORES (MAX_STORES)
    ) checker0 (
        .clk          (clk),
        .rst          (rst),
        .imem         (imem),
        .dmem         (dmem),
        .exp_stores   (exp_stores),
        .n_stores     (n_stores),
        .store_count  (store_count),
        .value_errors (value_errors),
        .other_errors (other_errors)
    );

    // both memories answer in the same cycle
    assign imem_rdata = imem_array[imem.addr[9:2]];

    // data port returns zero unless the read strobe is high
    assign dmem_rdata = dmem.read
                      ? {dmem_bytes[{dmem.addr[10:2], 2'd3}], dmem_bytes[{dmem.addr[10:2], 2'd2}],
                         dmem_bytes[{dmem.addr[10:2], 2'd1}], dmem_bytes[{dmem.addr[10:2], 2'd0}]}
                      : '0;

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // instruction encoders with field layouts from the RV32I spec
    function automatic word r_type(int f7, int f3, int rd, int rs1, int rs2);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], OP_ALU};
    endfunction

    function automatic word i_type(opcode_t op, int f3, int rd, int rs1, int imm);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
    endfunction

    function automatic word s_type(int f3, int rs2, int rs1, int imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], OP_STORE};
    endfunction

    function automatic word b_type(int f3, int rs1, int rs2, int imm);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], OP_BRANCH};
    endfunction

    function automatic word u_type(opcode_t op, int rd, int imm20);
        return {imm20[19:0], rd[4:0], op};
    endfunction

    function automatic word j_type(int rd, int imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], OP_JAL};
    endfunction

    function automatic word next_pc();
        return BOOT_PC + word'(n_prog) * 4;
    endfunction

    task automatic emit(word instr);
        program_words[n_prog] = instr;
        n_prog++;
    endtask

    task automatic expect_store(word addr, word data, logic [3:0] be);
        exp_stores[n_stores].addr  = addr;
        exp_stores[n_stores].wdata = data;
        exp_stores[n_stores].be    = be;
        exp_stores[n_stores].read  = 1'b0;
        exp_stores[n_stores].write = 1'b1;
        n_stores++;
    endtask

    // sw rs2 to the next result slot above x10
    task automatic store_reg(int rs2, word value);
        emit(s_type(2, rs2, 10, slot));
        expect_store(32'h200 + word'(slot), value, 4'hF);
        slot += 4;
    endtask

    task automatic alu_rr(int f7, int f3, word value);
        emit(r_type(f7, f3, 4, 1, 2));
        store_reg(4, value);
    endtask

    task automatic alu_ri(int f3, int imm, word value);
        emit(i_type(OP_ALUI, f3, 4, 1, imm));
        store_reg(4, value);
    endtask

    task automatic load_case(int f3, int off, word value);
        emit(i_type(OP_LOAD, f3, 4, 12, off));
        store_reg(4, value);
    endtask

    // skipped marker goes to 0x340 where no entry expects a store
    task automatic branch_case(int f3, int rs1, int rs2, logic taken);
        emit(b_type(f3, rs1, rs2, 8));
        if (taken) begin
            emit(s_type(2, 9, 11, 'h40));
        end else begin
            store_reg(9, MARKER);
        end
    endtask

    task automatic build_program();
        word pc_here;
        emit(u_type(OP_LUI, 1, int'(X1 >> 12)));
        emit(i_type(OP_ALUI, 0, 1, 1, int'(X1[11:0])));
        emit(i_type(OP_ALUI, 0, 2, 0, int'(X2)));
        emit(i_type(OP_ALUI, 0, 9, 0, int'(MARKER)));
        emit(i_type(OP_ALUI, 0, 10, 0, 'h200));
        emit(i_type(OP_ALUI, 0, 11, 0, 'h300));
        emit(i_type(OP_ALUI, 0, 12, 0, 'h400));
        // register forms
        alu_rr(0, 0, X1 + X2);
        alu_rr(32, 0, X1 - X2);
        alu_rr(0, 1, X1 << 7);
        alu_rr(0, 2, 32'd1);
        alu_rr(0, 3, 32'd0);
        alu_rr(0, 4, X1 ^ X2);
        alu_rr(0, 5, X1 >> 7);
        alu_rr(32, 5, (X1 >> 7) | 32'hFE00_0000);
        alu_rr(0, 6, X1 | X2);
        alu_rr(0, 7, X1 & X2);
        // immediate forms where addi with bit 30 set must still add
        alu_ri(0, -16, X1 - 32'd16);
        alu_ri(2, -1, 32'd1);
        alu_ri(3, -1, 32'd1);
        alu_ri(4, 'h7FF, X1 ^ 32'h0000_07FF);
        alu_ri(6, -256, X1 | 32'hFFFF_FF00);
        alu_ri(7, 'hF0, X1 & 32'h0000_00F0);
        alu_ri(1, 4, X1 << 4);
        alu_ri(5, 9, X1 >> 9);
        alu_ri(5, 'h409, (X1 >> 9) | 32'hFF80_0000);
        // upper immediates
        emit(u_type(OP_LUI, 4, 'hABCDE));
        store_reg(4, 32'hABCD_E000);
        pc_here = next_pc();
        emit(u_type(OP_AUIPC, 4, 'h12345));
        store_reg(4, pc_here + 32'h1234_5000);
        // narrow stores above x11
        emit(s_type(0, 1, 11, 1));
        expect_store(32'h301, {4{X1[7:0]}}, 4'b0010);
        emit(s_type(1, 1, 11, 2));
        expect_store(32'h302, {2{X1[15:0]}}, 4'b1100);
        emit(s_type(0, 1, 11, 3));
        expect_store(32'h303, {4{X1[7:0]}}, 4'b1000);
        emit(s_type(1, 2, 11, 0));
        expect_store(32'h300, {2{X2[15:0]}}, 4'b0011);
        // loads of the preloaded word at 0x400
        load_case(0, 0, 32'h0000_0073);
        load_case(0, 1, 32'hFFFF_FFF2);
        load_case(4, 1, 32'h0000_00F2);
        load_case(1, 0, 32'hFFFF_F273);
        load_case(5, 0, 32'h0000_F273);
        load_case(1, 2, 32'h0000_7A81);
        load_case(2, 0, LOAD_WORD);
        // each branch kind taken and not taken
        branch_case(0, 1, 1, 1'b1);
        branch_case(0, 1, 2, 1'b0);
        branch_case(1, 1, 2, 1'b1);
        branch_case(1, 1, 1, 1'b0);
        branch_case(4, 1, 2, 1'b1);
        branch_case(4, 2, 1, 1'b0);
        branch_case(5, 2, 1, 1'b1);
        branch_case(5, 1, 2, 1'b0);
        branch_case(6, 2, 1, 1'b1);
        branch_case(6, 1, 2, 1'b0);
        branch_case(7, 1, 2, 1'b1);
        branch_case(7, 2, 1, 1'b0);
        // jal over a marker and then the link value
        pc_here = next_pc();
        emit(j_type(5, 8));
        emit(s_type(2, 9, 11, 'h40));
        store_reg(5, pc_here + 32'd4);
        // jalr drops bit 0 of the sum and lands on the store after the marker
        pc_here = next_pc();
        emit(i_type(OP_ALUI, 0, 6, 0, int'(pc_here + 32'd12)));
        emit(i_type(OP_JALR, 0, 7, 6, 1));
        emit(s_type(2, 9, 11, 'h40));
        store_reg(7, pc_here + 32'd8);
        // x0 stays zero
        emit(i_type(OP_ALUI, 0, 0, 0, 'h55));
        store_reg(0, 32'd0);
        emit(r_type(0, 0, 0, 1, 2));
        store_reg(0, 32'd0);
        emit(j_type(0, 0));
    endtask

    initial begin
        int boot_idx;
        int failures;
        rst = 1'b1;
        n_prog = 0;
        n_stores = 0;
        slot = 0;
        build_program();
        boot_idx = int'(BOOT_PC >> 2);
        for (int i = 0; i < n_prog; i++) begin
            imem_array[boot_idx + i] = program_words[i];
        end
        for (int a = 0; a < 2048; a++) begin
            dmem_bytes[a] = 8'(a ^ (a >> 8) ^ 'h5a);
        end
        // load data goes in on a falling edge while the core is held in reset
        @(negedge clk);
        for (int i = 0; i < 4; i++) begin
            dmem_bytes['h400 + i] = LOAD_WORD[8*i +: 8];
        end
        repeat (15) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        waited = 0;
        while (store_count < n_stores && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        timed_out = (store_count < n_stores);
        failures = other_errors;
        if (timed_out) begin
            $display("timeout: the core issued %0d of %0d expected stores in %0d cycles",
                     store_count, n_stores, waited);
            failures++;
        end
        $display("value errors: %0d, other errors: %0d", value_errors, failures);
        if (value_errors != 0 || failures != 0) begin
            $display("Testbench failed");
        end else begin
            $display("Testbench passed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* build.f */
src/rv_isa_pkg.sv
src/rv_core_pkg.sv
src/rv_decoder.sv
src/rv_regfile.sv
src/rv_alu.sv
src/rv_pc_unit.sv
src/rv_lsu.sv
src/rv_core.sv
verif/rv_core_sva.sv
verif/rv_core_checker.sv
verif/rv_core_tb.sv

/* Makefile */
TOP := rv_core_tb

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -f build.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q "Testbench failed" sim.log; then exit 1; fi
	@grep -q "Testbench passed" sim.log

lint:
	verilator --lint-only -Wall --timing -f build.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log
